// ==== hw/spectrum_pkg.sv ====
`default_nettype none

package spectrum_pkg;

  localparam int AUDIO_W   = 16;
  localparam int SAMPLE_W  = 27;
  localparam int FRAC_W    = 23;
  localparam int LEVEL_W   = 11;
  localparam int NUM_BANDS = 6;

  // Signed 4.23 fixed point
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  typedef logic [LEVEL_W-1:0] level_t;

  // Denominator a1 is unity, so it is not stored
  typedef struct packed {
    sample_t b1;
    sample_t b2;
    sample_t b3;
    sample_t b4;
    sample_t b5;
    sample_t a2;
    sample_t a3;
    sample_t a4;
    sample_t a5;
  } band_coeff_t;

  // Index 0 is the lowest band
  localparam band_coeff_t BAND_COEFFS [NUM_BANDS] = '{
    // 10 Hz to 100 Hz
    '{b1: 27'h0000048, b2: 27'h0000000, b3: 27'h7FFFF70, b4: 27'h0000000,
      b5: 27'h0000048, a2: 27'h6011140, a3: 27'h3FCCDAA, a4: 27'h60330ED,
      a5: 27'h07EF029},
    // 100 Hz to 500 Hz
    '{b1: 27'h0000583, b2: 27'h0000000, b3: 27'h7FFF4FA, b4: 27'h0000000,
      b5: 27'h0000583, a2: 27'h604CAFA, a3: 27'h3F1C349, a4: 27'h60E18C3,
      a5: 27'h07B58FB},
    // 500 Hz to 1 kHz
    '{b1: 27'h0000892, b2: 27'h0000000, b3: 27'h7FFEEDB, b4: 27'h0000000,
      b5: 27'h0000892, a2: 27'h60676FA, a3: 27'h3ED4B6C, a4: 27'h61207B2,
      a5: 27'h07A360D},
    // 1 kHz to 5 kHz
    '{b1: 27'h001D7E8, b2: 27'h0000000, b3: 27'h7FC5030, b4: 27'h0000000,
      b5: 27'h001D7E8, a2: 27'h633FA03, a3: 27'h271581F, a4: 27'h68254EA,
      a5: 27'h058658B},
    // 5 kHz to 10 kHz
    '{b1: 27'h002C477, b2: 27'h0000000, b3: 27'h7FA7711, b4: 27'h0000000,
      b5: 27'h002C477, a2: 27'h66A9DF0, a3: 27'h209FEAD, a4: 27'h6BF5FBF,
      a5: 27'h05096DD},
    // 10 kHz to 20 kHz
    '{b1: 27'h0093EDC, b2: 27'h0000000, b3: 27'h7ED8248, b4: 27'h0000000,
      b5: 27'h0093EDC, a2: 27'h7168071, a3: 27'h0FC755A, a4: 27'h770E5BC,
      a5: 27'h032F6A7}
  };

  // Full product, rescaled to 4.23 and truncated
  function automatic sample_t fx_mul(input sample_t a, input sample_t b);
    logic signed [2*SAMPLE_W-1:0] prod;
    logic signed [2*SAMPLE_W-1:0] scaled;
    prod   = a * b;
    scaled = prod >>> FRAC_W;
    return scaled[SAMPLE_W-1:0];
  endfunction

endpackage

`default_nettype wire

// ==== hw/sample_input_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module sample_input_stage (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic signed [spectrum_pkg::AUDIO_W-1:0] audio_in_l,
  input  logic signed [spectrum_pkg::AUDIO_W-1:0] audio_in_r,
  input  logic                                   sample_valid,
  output logic signed [spectrum_pkg::AUDIO_W-1:0] audio_out_l,
  output logic signed [spectrum_pkg::AUDIO_W-1:0] audio_out_r,
  output spectrum_pkg::sample_t                  mono_sample,
  output logic                                   mono_valid
);

  import spectrum_pkg::*;

  // One bit of growth so the sum cannot overflow
  logic signed [AUDIO_W:0] stereo_sum;

  assign stereo_sum = {audio_in_l[AUDIO_W-1], audio_in_l}
                    + {audio_in_r[AUDIO_W-1], audio_in_r};

  always_ff @(posedge clk) begin
    if (reset) begin
      audio_out_l <= '0;
      audio_out_r <= '0;
      mono_valid  <= 1'b0;
    end else begin
      mono_valid <= sample_valid;
      if (sample_valid) begin
        audio_out_l <= audio_in_l;
        audio_out_r <= audio_in_r;
      end
    end
  end

  // Halving the sum puts input bit 15 on sample bit 23, so the sum's
  // LSB lands one place lower and no precision is lost
  always_ff @(posedge clk) begin
    if (sample_valid) begin
      mono_sample <= sample_t'(stereo_sum) <<< (FRAC_W - AUDIO_W);
    end
  end

endmodule

`default_nettype wire

// ==== hw/band_filter.sv ====
`timescale 1ns/1ns
`default_nettype none

module band_filter #(
  parameter int BAND_INDEX = 0
) (
  input  logic                  clk,
  input  logic                  reset,
  input  spectrum_pkg::sample_t mono_sample,
  input  logic                  mono_valid,
  output spectrum_pkg::level_t  band_mag,
  output logic                  mag_valid
);

  import spectrum_pkg::*;

  localparam band_coeff_t COEFF = BAND_COEFFS[BAND_INDEX];

  // Delay line of the transposed form
  sample_t z1;
  sample_t z2;
  sample_t z3;
  sample_t z4;

  sample_t y_q;
  sample_t y_next;

  // Feedforward products
  sample_t b1_x;
  sample_t b2_x;
  sample_t b3_x;
  sample_t b4_x;
  sample_t b5_x;

  // Feedback products, taken from the new output
  sample_t a2_y;
  sample_t a3_y;
  sample_t a4_y;
  sample_t a5_y;

  assign b1_x = fx_mul(COEFF.b1, mono_sample);
  assign b2_x = fx_mul(COEFF.b2, mono_sample);
  assign b3_x = fx_mul(COEFF.b3, mono_sample);
  assign b4_x = fx_mul(COEFF.b4, mono_sample);
  assign b5_x = fx_mul(COEFF.b5, mono_sample);

  assign y_next = b1_x + z1;

  assign a2_y = fx_mul(COEFF.a2, y_next);
  assign a3_y = fx_mul(COEFF.a3, y_next);
  assign a4_y = fx_mul(COEFF.a4, y_next);
  assign a5_y = fx_mul(COEFF.a5, y_next);

  always_ff @(posedge clk) begin
    if (reset) begin
      z1        <= '0;
      z2        <= '0;
      z3        <= '0;
      z4        <= '0;
      y_q       <= '0;
      mag_valid <= 1'b0;
    end else begin
      mag_valid <= mono_valid;
      if (mono_valid) begin
        y_q <= y_next;
        z1  <= b2_x + z2 - a2_y;
        z2  <= b3_x + z3 - a3_y;
        z3  <= b4_x + z4 - a4_y;
        // Last element has no older state to add
        z4  <= b5_x - a5_y;
      end
    end
  end

  // Ones-complement magnitude of the top bits of y
  assign band_mag = y_q[SAMPLE_W-1] ? ~y_q[SAMPLE_W-1 -: LEVEL_W]
                                    : y_q[SAMPLE_W-1 -: LEVEL_W];

endmodule

`default_nettype wire

// ==== hw/level_meter.sv ====
`timescale 1ns/1ns
`default_nettype none

module level_meter #(
  parameter int DECAY_SAMPLES = 64
) (
  input  logic                 clk,
  input  logic                 reset,
  input  spectrum_pkg::level_t band_mag,
  input  logic                 mag_valid,
  output spectrum_pkg::level_t level
);

  localparam int CNT_W = $clog2(DECAY_SAMPLES + 1);

  logic [CNT_W-1:0] decay_cnt;
  logic             decay_due;
  logic             new_peak;

  assign new_peak  = (band_mag >= level);
  assign decay_due = (decay_cnt == CNT_W'(DECAY_SAMPLES - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      level     <= '0;
      decay_cnt <= '0;
    end else if (mag_valid) begin
      if (new_peak) begin
        // Peak captured at once, hold time restarts
        level     <= band_mag;
        decay_cnt <= '0;
      end else if (decay_due) begin
        // band_mag is below level here, so one step down cannot pass it
        level     <= level - 1'b1;
        decay_cnt <= '0;
      end else begin
        decay_cnt <= decay_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/spectrum_analyzer_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module spectrum_analyzer_top #(
  parameter int DECAY_SAMPLES = 64
) (
  input  logic                                           clk,
  input  logic                                           reset,
  input  logic signed [spectrum_pkg::AUDIO_W-1:0]         audio_in_l,
  input  logic signed [spectrum_pkg::AUDIO_W-1:0]         audio_in_r,
  input  logic                                           sample_valid,
  output logic signed [spectrum_pkg::AUDIO_W-1:0]         audio_out_l,
  output logic signed [spectrum_pkg::AUDIO_W-1:0]         audio_out_r,
  output spectrum_pkg::level_t [spectrum_pkg::NUM_BANDS-1:0] band_levels,
  output logic                                           levels_valid
);

  import spectrum_pkg::*;

  sample_t                mono_sample;
  logic                   mono_valid;
  level_t [NUM_BANDS-1:0] band_mag;
  logic   [NUM_BANDS-1:0] mag_valid;

  sample_input_stage i_input_stage (
    .clk          (clk),
    .reset        (reset),
    .audio_in_l   (audio_in_l),
    .audio_in_r   (audio_in_r),
    .sample_valid (sample_valid),
    .audio_out_l  (audio_out_l),
    .audio_out_r  (audio_out_r),
    .mono_sample  (mono_sample),
    .mono_valid   (mono_valid)
  );

  for (genvar b = 0; b < NUM_BANDS; b++) begin : g_band
    band_filter #(
      .BAND_INDEX (b)
    ) i_filter (
      .clk         (clk),
      .reset       (reset),
      .mono_sample (mono_sample),
      .mono_valid  (mono_valid),
      .band_mag    (band_mag[b]),
      .mag_valid   (mag_valid[b])
    );

    level_meter #(
      .DECAY_SAMPLES (DECAY_SAMPLES)
    ) i_meter (
      .clk       (clk),
      .reset     (reset),
      .band_mag  (band_mag[b]),
      .mag_valid (mag_valid[b]),
      .level     (band_levels[b])
    );
  end

  // Meters update one cycle after the filters, all bands in step
  always_ff @(posedge clk) begin
    if (reset) begin
      levels_valid <= 1'b0;
    end else begin
      levels_valid <= mag_valid[0];
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 16
) (
  input  logic reset_req,
  output logic clk,
  output logic reset
);

  int unsigned cycle_cnt = 0;

  initial begin
    clk = 1'b0;
  end

  always #(PERIOD_NS / 2) clk = ~clk;

  // Power-on reset for the first cycles, later only on request
  always @(posedge clk) begin
    if (cycle_cnt < RESET_CYCLES) begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  assign reset = (cycle_cnt < RESET_CYCLES) || reset_req;

endmodule

`default_nettype wire

// ==== test/spectrum_analyzer_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module spectrum_analyzer_tb;

  import spectrum_pkg::*;

  localparam int DECAY_SAMPLES = 4;
  localparam int N_DENSE       = 40;
  localparam int N_SPARSE      = 30;
  localparam int N_RANDOM      = 300;
  localparam int N_BURST       = 32;
  localparam int N_SILENCE     = 120;
  localparam int N_IDLE_TEST   = 10;
  localparam int N_PRE_RESET   = 20;
  localparam int N_POST_RESET  = 50;
  localparam int TOTAL_SAMPLES = N_DENSE + N_SPARSE + N_RANDOM + N_BURST + N_SILENCE
                               + N_IDLE_TEST + N_PRE_RESET + N_POST_RESET;
  localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * 4 + 200;
  localparam int DRAIN_LIMIT     = 10;

  typedef level_t [NUM_BANDS-1:0] level_vec_t;

  logic                      clk;
  logic                      reset;
  logic                      reset_req;
  logic signed [AUDIO_W-1:0] audio_in_l;
  logic signed [AUDIO_W-1:0] audio_in_r;
  logic                      sample_valid;
  logic signed [AUDIO_W-1:0] audio_out_l;
  logic signed [AUDIO_W-1:0] audio_out_r;
  level_vec_t                band_levels;
  logic                      levels_valid;

  int seed;
  int errors;
  int tests_run;
  int tests_failed;
  int test_err_base;

  // Reference model state
  sample_t z_model [NUM_BANDS][4];
  level_t  lvl_model [NUM_BANDS];
  int      decay_model [NUM_BANDS];

  // Expected levels, one entry per sample in flight
  level_vec_t                exp_q [$];
  level_vec_t                cur_levels;
  logic [2:0]                valid_pipe;
  logic signed [AUDIO_W-1:0] last_l;
  logic signed [AUDIO_W-1:0] last_r;

  tb_clock_gen #(
    .PERIOD_NS    (20),
    .RESET_CYCLES (16)
  ) i_clock_gen (
    .reset_req (reset_req),
    .clk       (clk),
    .reset     (reset)
  );

  spectrum_analyzer_top #(
    .DECAY_SAMPLES (DECAY_SAMPLES)
  ) i_dut (
    .clk          (clk),
    .reset        (reset),
    .audio_in_l   (audio_in_l),
    .audio_in_r   (audio_in_r),
    .sample_valid (sample_valid),
    .audio_out_l  (audio_out_l),
    .audio_out_r  (audio_out_r),
    .band_levels  (band_levels),
    .levels_valid (levels_valid)
  );

  function automatic logic signed [AUDIO_W-1:0] random_audio();
    int r;
    r = $random(seed);
    return r[AUDIO_W-1:0];
  endfunction

  function automatic int random_gap();
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % 3 + 1;
  endfunction

  task automatic model_reset();
    int b;
    for (b = 0; b < NUM_BANDS; b++) begin
      z_model[b][0]  = '0;
      z_model[b][1]  = '0;
      z_model[b][2]  = '0;
      z_model[b][3]  = '0;
      lvl_model[b]   = '0;
      decay_model[b] = 0;
    end
  endtask

  task automatic update_meter(input int b, input level_t mag);
    level_t stepped;
    if (mag >= lvl_model[b]) begin
      lvl_model[b]   = mag;
      decay_model[b] = 0;
    end else begin
      decay_model[b]++;
      if (decay_model[b] == DECAY_SAMPLES) begin
        // Slow fall, floored at the current magnitude
        stepped        = lvl_model[b] - 1'b1;
        lvl_model[b]   = (stepped < mag) ? mag : stepped;
        decay_model[b] = 0;
      end
    end
  endtask

  task automatic model_step(input logic signed [AUDIO_W-1:0] l,
                            input logic signed [AUDIO_W-1:0] r);
    int                 sum;
    sample_t            x;
    sample_t            y;
    band_coeff_t        c;
    logic [LEVEL_W-1:0] top;
    level_t             mag;
    level_vec_t         expected;
    int                 b;
    sum = int'(l) + int'(r);
    // Mean of the pair with input bit 15 on sample bit 23
    x = sample_t'(sum * 128);
    for (b = 0; b < NUM_BANDS; b++) begin
      c = BAND_COEFFS[b];
      y = fx_mul(c.b1, x) + z_model[b][0];
      z_model[b][0] = fx_mul(c.b2, x) + z_model[b][1] - fx_mul(c.a2, y);
      z_model[b][1] = fx_mul(c.b3, x) + z_model[b][2] - fx_mul(c.a3, y);
      z_model[b][2] = fx_mul(c.b4, x) + z_model[b][3] - fx_mul(c.a4, y);
      z_model[b][3] = fx_mul(c.b5, x) - fx_mul(c.a5, y);
      top = y[SAMPLE_W-1 -: LEVEL_W];
      mag = y[SAMPLE_W-1] ? ~top : top;
      update_meter(b, mag);
      expected[b] = lvl_model[b];
    end
    exp_q.push_back(expected);
  endtask

  task automatic drive_sample(input logic signed [AUDIO_W-1:0] l,
                              input logic signed [AUDIO_W-1:0] r);
    @(posedge clk);
    audio_in_l   <= l;
    audio_in_r   <= r;
    sample_valid <= 1'b1;
    model_step(l, r);
  endtask

  // Idle cycles, optionally with changing inputs that must be ignored
  task automatic idle_cycles(input int n, input bit wiggle);
    int i;
    for (i = 0; i < n; i++) begin
      @(posedge clk);
      sample_valid <= 1'b0;
      if (wiggle) begin
        audio_in_l <= random_audio();
        audio_in_r <= random_audio();
      end
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d samples never produced levels_valid", exp_q.size());
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = errors - test_err_base;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("Test %0d %s: %0d errors", tests_run, name, errs);
    test_err_base = errors;
  endtask

  task automatic check_levels(input level_vec_t exp);
    int b;
    for (b = 0; b < NUM_BANDS; b++) begin
      assert (band_levels[b] === exp[b]) else begin
        $display("FAIL band_levels[%0d]: got %h expected %h at %0t ns",
                 b, band_levels[b], exp[b], $time);
        errors++;
      end
    end
  endtask

  // Checks on values settled in the cycle before each edge
  always @(posedge clk) begin : output_check
    level_vec_t popped;
    if (reset) begin
      valid_pipe <= '0;
      last_l     <= '0;
      last_r     <= '0;
      cur_levels <= '0;
      exp_q.delete();
    end else begin
      valid_pipe <= {valid_pipe[1:0], sample_valid};
      if (sample_valid) begin
        last_l <= audio_in_l;
        last_r <= audio_in_r;
      end
      assert (audio_out_l === last_l) else begin
        $display("FAIL audio_out_l: got %h expected %h at %0t ns", audio_out_l, last_l, $time);
        errors++;
      end
      assert (audio_out_r === last_r) else begin
        $display("FAIL audio_out_r: got %h expected %h at %0t ns", audio_out_r, last_r, $time);
        errors++;
      end
      // Three cycles from strobe to levels
      assert (levels_valid === valid_pipe[2]) else begin
        $display("FAIL levels_valid: got %h expected %h at %0t ns",
                 levels_valid, valid_pipe[2], $time);
        errors++;
      end
      if (levels_valid) begin
        if (exp_q.size() == 0) begin
          $display("levels_valid came at %0t ns with no sample pending", $time);
          errors++;
        end else begin
          popped = exp_q.pop_front();
          check_levels(popped);
          cur_levels <= popped;
        end
      end else begin
        check_levels(cur_levels);
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin : main
    int i;
    logic signed [AUDIO_W-1:0] v;
    seed          = 37;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    test_err_base = 0;
    audio_in_l    = '0;
    audio_in_r    = '0;
    sample_valid  = 1'b0;
    reset_req     = 1'b0;
    model_reset();

    @(posedge clk);
    while (reset) @(posedge clk);

    idle_cycles(10, 1'b1);
    finish_test("reset state");

    for (i = 0; i < N_DENSE; i++) begin
      drive_sample(random_audio(), random_audio());
    end
    for (i = 0; i < N_SPARSE; i++) begin
      drive_sample(random_audio(), random_audio());
      idle_cycles(random_gap(), 1'b1);
    end
    idle_cycles(1, 1'b0);
    wait_drain();
    finish_test("audio pass-through");

    for (i = 0; i < N_RANDOM; i++) begin
      drive_sample(random_audio(), random_audio());
      if (($random(seed) & 3) == 0) begin
        idle_cycles(1, 1'b1);
      end
    end
    idle_cycles(1, 1'b0);
    wait_drain();
    finish_test("random levels");

    // Full-scale square tone, then silence for the decay
    for (i = 0; i < N_BURST; i++) begin
      v = (i % 8 < 4) ? 16'sh7fff : 16'sh8000;
      drive_sample(v, v);
    end
    for (i = 0; i < N_SILENCE; i++) begin
      drive_sample('0, '0);
    end
    idle_cycles(1, 1'b0);
    wait_drain();
    finish_test("burst and decay");

    for (i = 0; i < N_IDLE_TEST; i++) begin
      drive_sample(random_audio(), random_audio());
    end
    idle_cycles(1, 1'b0);
    wait_drain();
    idle_cycles(50, 1'b1);
    finish_test("idle cycles");

    for (i = 0; i < N_PRE_RESET; i++) begin
      drive_sample(random_audio(), random_audio());
    end
    // Reset with samples still in the pipeline
    @(posedge clk);
    sample_valid <= 1'b0;
    reset_req    <= 1'b1;
    repeat (4) @(posedge clk);
    model_reset();
    reset_req <= 1'b0;
    idle_cycles(3, 1'b1);
    for (i = 0; i < N_POST_RESET; i++) begin
      drive_sample(random_audio(), random_audio());
      if (($random(seed) & 1) == 0) begin
        idle_cycles(random_gap(), 1'b1);
      end
    end
    idle_cycles(1, 1'b0);
    wait_drain();
    finish_test("reset mid-run");

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
hw/spectrum_pkg.sv
hw/sample_input_stage.sv
hw/band_filter.sv
hw/level_meter.sv
hw/spectrum_analyzer_top.sv
test/tb_clock_gen.sv
test/spectrum_analyzer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module spectrum_analyzer_tb \
  -o spectrum_sim || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/spectrum_sim)"
echo "$sim_out"

grep -qx "NO ERRORS" <<< "$sim_out" && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
